/* design/parser_consts.svh */
`ifndef PARSER_CONSTS_SVH
`define PARSER_CONSTS_SVH

////////////////////////////////////////////////////////////
// frame geometry
////////////////////////////////////////////////////////////
`define COLS 8          // window positions per row
`define ROWS 6          // frame rows
`define COL_W 4         // holds 0..COLS
`define ROW_W 3         // holds 0..ROWS

////////////////////////////////////////////////////////////
// scan timing
////////////////////////////////////////////////////////////
`define WIN_DELAY 4     // dwell per column position
`define DLY_W 3
`define COL_SYNC 3      // column-end wait
`define SYNC_W 3
`define VLD_START 1     // mac valid once dwell passes this

////////////////////////////////////////////////////////////
// banks and words
////////////////////////////////////////////////////////////
`define BANKS 16
`define ADDR_W 9
`define BANK_HALF 4     // base of the second bank half
`define LANES 4         // channels per word
`define PIX_W 8

`endif

/* design/parser_pkg.sv */
`default_nettype none

`include "parser_consts.svh"

package parser_pkg;

	typedef enum logic [2:0] {
		IDLE,
		ROW0,
		ROW_ODD,
		ROW_EVEN,
		ROW_END,
		COL_END
	} scanStateT;

	typedef logic [`BANKS-1:0][`ADDR_W-1:0] bankAddrT;

	// one bank word, lane 0 in the low byte
	typedef logic [`LANES-1:0][`PIX_W-1:0] bankWordT;

	typedef bankWordT [`BANKS-1:0] bankDataT;   // index is slot*4 + lane

	typedef bankWordT [`BANKS-1:0] windowT;     // index is row*4 + column

endpackage

`default_nettype wire

/* design/scanFsm.sv */
`default_nettype none

`include "parser_consts.svh"

module scanFsm import parser_pkg::*; (
	input wire clk,
	input wire rstn,
	input wire start,
	output scanStateT state,
	output logic [`COL_W-1:0] col,
	output logic colPhase,
	output logic advance,
	output logic colEnd,
	output scanStateT lastPrev,
	output logic macValid,
	output logic busy
);

	localparam logic [`COL_W-1:0] ColLast = `COLS - 1;
	localparam logic [`COL_W-1:0] ColStop = `COLS;
	localparam logic [`ROW_W-1:0] RowLast = `ROWS - 1;
	localparam logic [`DLY_W-1:0] DwellMax = `WIN_DELAY;
	localparam logic [`DLY_W-1:0] VldStart = `VLD_START;
	localparam logic [`SYNC_W-1:0] SyncMax = `COL_SYNC;

	scanStateT nextState;
	logic [`ROW_W-1:0] row;
	logic [`DLY_W-1:0] dwellCnt;
	logic [`SYNC_W-1:0] syncCnt;
	logic syncDone;
	logic rowState;

	assign rowState = (state != IDLE) && (state != COL_END);
	assign colEnd = rowState && (col == ColStop);
	assign advance = rowState && (dwellCnt == DwellMax) && (col != ColLast);
	assign macValid = dwellCnt > VldStart;
	assign busy = state != IDLE;

	////////////////////////////////////////////////////////////
	// row-type state machine
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= IDLE;
		end else if (start) begin   // frozen while start is low
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			IDLE: nextState = ROW0;
			ROW0, ROW_ODD, ROW_EVEN, ROW_END: begin
				if (colEnd) begin
					nextState = COL_END;
				end
			end
			COL_END: begin
				if (syncDone) begin
					case (lastPrev)
						ROW0: nextState = ROW_ODD;
						ROW_ODD: nextState = ROW_EVEN;
						ROW_EVEN: nextState = ROW_ODD;
						default: nextState = IDLE;   // frame done
					endcase
					if (row == RowLast) begin
						nextState = ROW_END;
					end
				end
			end
			default: nextState = IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////
	// column, row and dwell counters
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			col <= '0;
			row <= '0;
			dwellCnt <= '0;
			colPhase <= 1'b0;
			lastPrev <= IDLE;
		end else if (start) begin
			if (state == IDLE) begin
				col <= '0;
				row <= '0;
				dwellCnt <= '0;
				colPhase <= 1'b0;
			end else if (colEnd) begin
				col <= '0;
				colPhase <= 1'b0;
				row <= row + 1'b1;
				lastPrev <= state;   // picks the next row type
			end else if (rowState) begin
				if (dwellCnt == DwellMax) begin
					dwellCnt <= '0;
					col <= col + 1'b1;
					colPhase <= ~colPhase;
				end else begin
					dwellCnt <= dwellCnt + 1'b1;
				end
			end
		end
	end

	// column-end wait, done flag registered one cycle late
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			syncCnt <= '0;
			syncDone <= 1'b0;
		end else if (start) begin
			if (state == COL_END && !syncDone) begin
				syncCnt <= syncCnt + 1'b1;
				syncDone <= syncCnt == SyncMax;
			end else begin
				syncCnt <= '0;
				syncDone <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* design/bankAddrGen.sv */
`default_nettype none

`include "parser_consts.svh"

module bankAddrGen import parser_pkg::*; (
	input wire clk,
	input wire rstn,
	input wire start,
	input scanStateT state,
	input wire [`COL_W-1:0] col,
	input wire colPhase,
	input wire advance,
	input wire colEnd,
	output bankAddrT bankAddr,
	output logic [`BANKS-1:0] chipSel
);

	localparam int SlotN = `BANKS / `LANES;
	localparam logic [`ADDR_W-1:0] HalfBase = `BANK_HALF;
	localparam logic [`BANKS-1:0] FirstColMask = 16'h7777;   // lane 3 of each slot off

	logic rowToggleOdd;
	logic rowToggleEven;
	logic [SlotN-1:0] halfSlots;   // slots restarting at HalfBase

	always_comb begin
		case (state)
			ROW0: halfSlots = 4'b0001;
			ROW_ODD: halfSlots = rowToggleOdd ? 4'b1000 : 4'b0111;
			ROW_EVEN: halfSlots = rowToggleEven ? 4'b0001 : 4'b1110;
			default: halfSlots = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// bank address registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			bankAddr <= '0;
			rowToggleOdd <= 1'b0;
			rowToggleEven <= 1'b0;
		end else if (state == IDLE) begin
			bankAddr <= '0;
			rowToggleOdd <= 1'b0;
			rowToggleEven <= 1'b0;
		end else if (start) begin
			if (colEnd && state != ROW_END) begin
				for (int b = 0; b < `BANKS; b++) begin
					bankAddr[b] <= halfSlots[b / `LANES] ? HalfBase : '0;
				end
				if (state == ROW_ODD) begin
					rowToggleOdd <= ~rowToggleOdd;
				end
				if (state == ROW_EVEN) begin
					rowToggleEven <= ~rowToggleEven;
				end
			end else if (advance) begin
				// lanes 0/1 on odd phase, lanes 2/3 on even phase
				for (int b = 0; b < `BANKS; b++) begin
					if (colPhase == ((b % `LANES) < 2)) begin
						bankAddr[b] <= bankAddr[b] + 1'b1;
					end
				end
			end
		end
	end

	always_comb begin
		chipSel = '0;
		if (state != IDLE && state != COL_END) begin
			chipSel = '1;
			if (col == '0) begin
				chipSel = chipSel & FirstColMask;
			end
			if (state == ROW0) begin
				chipSel[`BANKS-1 -: `LANES] = '0;   // top slot padded
			end
			if (state == ROW_END) begin
				chipSel[`LANES-1:0] = '0;   // bottom slot padded
			end
		end
	end

endmodule

`default_nettype wire

/* design/windowAssembler.sv */
`default_nettype none

`include "parser_consts.svh"

module windowAssembler import parser_pkg::*; (
	input wire clk,
	input wire rstn,
	input wire start,
	input scanStateT state,
	input wire [`COL_W-1:0] col,
	input wire colPhase,
	input bankDataT bankData,
	output windowT window
);

	localparam logic [`COL_W-1:0] ColLast = `COLS - 1;
	localparam int WinN = `LANES;   // square window, one lane per column

	bankDataT captured;
	logic rowState;
	logic [1:0] rowRot;    // window row to row slot
	logic [1:0] laneRot;   // window column to bank lane

	assign rowState = (state != IDLE) && (state != COL_END);

	////////////////////////////////////////////////////////////
	// bank word capture
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			captured <= '0;
		end else if (start && state != COL_END) begin
			captured <= bankData;
		end
	end

	// odd and last rows start at slot 1, first and even rows at slot 3
	always_comb begin
		if (state == ROW_ODD || state == ROW_END) begin
			rowRot = 2'd1;
		end else begin
			rowRot = 2'd3;
		end
		laneRot = colPhase ? 2'd1 : 2'd3;
	end

	////////////////////////////////////////////////////////////
	// window rotation with zero padding
	////////////////////////////////////////////////////////////
	always_comb begin
		window = '0;
		if (rowState) begin
			for (int r = 0; r < WinN; r++) begin
				for (int c = 0; c < WinN; c++) begin
					if (!((state == ROW0 && r == 0) ||
						(state == ROW_END && r == WinN - 1) ||
						(col == '0 && c == 0) ||
						(col == ColLast && c == WinN - 1))) begin
						window[r * WinN + c] =
							captured[{2'(r + int'(rowRot)), 2'(c + int'(laneRot))}];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/featureParser.sv */
`default_nettype none

`include "parser_consts.svh"

module featureParser import parser_pkg::*; (
	input wire clk,
	input wire rstn,
	input wire start,
	input bankDataT bankData,
	output bankAddrT bankAddr,
	output logic [`BANKS-1:0] chipSel,
	output windowT window,
	output logic macValid,
	output logic busy
);

	scanStateT state;
	scanStateT lastPrev;   // row type before the current column end
	logic [`COL_W-1:0] col;
	logic colPhase;
	logic advance;
	logic colEnd;

	scanFsm fsm_i (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.state(state),
		.col(col),
		.colPhase(colPhase),
		.advance(advance),
		.colEnd(colEnd),
		.lastPrev(lastPrev),
		.macValid(macValid),
		.busy(busy)
	);

	bankAddrGen addr_i (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.state(state),
		.col(col),
		.colPhase(colPhase),
		.advance(advance),
		.colEnd(colEnd),
		.bankAddr(bankAddr),
		.chipSel(chipSel)
	);

	windowAssembler win_i (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.state(state),
		.col(col),
		.colPhase(colPhase),
		.bankData(bankData),
		.window(window)
	);

endmodule

`default_nettype wire

/* tb/featureParser_asserts.sv */
`default_nettype none

`include "parser_consts.svh"

module featureParser_asserts import parser_pkg::*; (
	input wire clk,
	input wire rstn,
	input wire busy,
	input wire macValid,
	input wire [`BANKS-1:0] chipSel,
	input scanStateT state,
	input scanStateT lastPrev
);

	////////////////////////////////////////////////////////////
	// top level protocol checks
	////////////////////////////////////////////////////////////
	validNeedsBusy: assert property (@(posedge clk) disable iff (!rstn)
		!busy |-> !macValid)
		else $error("macValid high while not busy");

	csOffOutsideRows: assert property (@(posedge clk) disable iff (!rstn)
		(state == IDLE || state == COL_END) |-> chipSel == '0)
		else $error("chipSel active outside a row state");

	// frame ends only from the column end of the last row
	busyFallsAfterLast: assert property (@(posedge clk) disable iff (!rstn)
		$fell(busy) |-> ($past(state) == COL_END && lastPrev == ROW_END))
		else $error("busy fell before the last row finished");

endmodule

`default_nettype wire

/* tb/featureParser_tb.sv */
`default_nettype none

`include "parser_consts.svh"

module featureParser_tb import parser_pkg::*; ();

	localparam int Period = 10;
	localparam int ResetCycles = 10;
	localparam int RowLen = `COLS * (`WIN_DELAY + 1) + 1;   // plus the col-end detect cycle
	localparam int FrameLen = `ROWS * (RowLen + `COL_SYNC + 2);
	localparam int VldHigh = `WIN_DELAY - `VLD_START;
	localparam int Depth = 1 << `ADDR_W;
	localparam int HoldCycles = 20;
	localparam int TestIdle = 0;
	localparam int TestFrame = 1;
	localparam int TestCs = 2;
	localparam int TestWin = 3;
	localparam int TestValid = 4;
	localparam int TestAddr = 5;
	localparam int TestHold = 6;
	localparam int TestN = 7;

	logic clk = 1'b0;
	logic rstn;
	logic start;
	bankDataT bankData;
	bankAddrT bankAddr;
	logic [`BANKS-1:0] chipSel;
	windowT window;
	logic macValid;
	logic busy;

	bankWordT mem [`BANKS][Depth];
	bankDataT pending;   // read data one cycle behind the address
	logic [31:0] stim [0:127];
	int chkRow [32];
	int chkCol [32];
	int chkIdx [32];
	bankWordT chkWord [32];
	bit chkSeen [32];
	int nChecks;
	int testErrors [TestN];
	string testNames [TestN] = '{"idle", "frame", "chipsel", "window", "valid", "address", "hold"};

	featureParser dut_i (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.bankData(bankData),
		.bankAddr(bankAddr),
		.chipSel(chipSel),
		.window(window),
		.macValid(macValid),
		.busy(busy)
	);

	bind featureParser featureParser_asserts asrt_i (
		.clk(clk),
		.rstn(rstn),
		.busy(busy),
		.macValid(macValid),
		.chipSel(chipSel),
		.state(state),
		.lastPrev(lastPrev)
	);

	always #(Period / 2) clk = ~clk;

	// sync bank model that keeps its last word while deselected
	always @(negedge clk) begin
		bankData <= pending;
		for (int b = 0; b < `BANKS; b++) begin
			if (chipSel[b]) begin
				pending[b] = mem[b][bankAddr[b]];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////
	task automatic checkWord(input int t, input string what, input bankWordT exp,
		input bankWordT act);
		if (act !== exp) begin
			$display("ERROR %s %s: expected %h, actual %h", testNames[t], what, exp, act);
			testErrors[t]++;
		end
	endtask

	task automatic checkMask(input int t, input string what, input logic [`BANKS-1:0] exp,
		input logic [`BANKS-1:0] act);
		if (act !== exp) begin
			$display("ERROR %s %s: expected %h, actual %h", testNames[t], what, exp, act);
			testErrors[t]++;
		end
	endtask

	task automatic checkAddr(input int t, input string what, input bankAddrT exp,
		input bankAddrT act);
		if (act !== exp) begin
			$display("ERROR %s %s: expected %h, actual %h", testNames[t], what, exp, act);
			testErrors[t]++;
		end
	endtask

	task automatic checkBit(input int t, input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %s %s: expected %b, actual %b", testNames[t], what, exp, act);
			testErrors[t]++;
		end
	endtask

	task automatic checkCount(input int t, input string what, input int exp, input int act);
		if (act != exp) begin
			$display("ERROR %s %s: expected %0d, actual %0d", testNames[t], what, exp, act);
			testErrors[t]++;
		end
	endtask

	task automatic finishTest(input int t);
		$display("test %-8s %s", testNames[t], (testErrors[t] == 0) ? "ok" : "FAILED");
	endtask

	////////////////////////////////////////////////////////////
	// expected values
	////////////////////////////////////////////////////////////
	function automatic scanStateT rowTypeOf(input int row);
		if (row == 0) return ROW0;
		if (row == `ROWS - 1) return ROW_END;
		return (row % 2 == 1) ? ROW_ODD : ROW_EVEN;
	endfunction

	function automatic logic [`BANKS-1:0] expectedMask(input int row, input int col);
		logic [`BANKS-1:0] m;
		m = '1;
		if (col == 0) m = m & 16'h7777;   // lane 3 padded
		if (rowTypeOf(row) == ROW0) m[15:12] = '0;
		if (rowTypeOf(row) == ROW_END) m[3:0] = '0;
		return m;
	endfunction

	// slots that start the row at the half base
	function automatic logic [3:0] halfSlotsFor(input int row);
		case (row)
			1: return 4'b0001;
			2: return 4'b0111;
			3: return 4'b1110;
			4: return 4'b1000;
			5: return 4'b0001;
			default: return 4'b0000;
		endcase
	endfunction

	function automatic bankAddrT expectedAddr(input int row, input int col);
		bankAddrT a;
		logic [3:0] half;
		int step;
		half = halfSlotsFor(row);
		for (int b = 0; b < `BANKS; b++) begin
			step = ((b % `LANES) >= 2) ? (col + 1) / 2 : col / 2;   // even cols step lanes 2/3
			a[b] = `ADDR_W'((half[b / `LANES] ? `BANK_HALF : 0) + step);
		end
		return a;
	endfunction

	task automatic samplePosition(input int pos);
		int row;
		int col;
		row = pos / `COLS;
		col = pos % `COLS;
		checkMask(TestCs, $sformatf("row %0d col %0d", row, col), expectedMask(row, col), chipSel);
		checkAddr(TestAddr, $sformatf("row %0d col %0d", row, col), expectedAddr(row, col),
			bankAddr);
		for (int j = 0; j < nChecks; j++) begin
			if (chkRow[j] == row && chkCol[j] == col) begin
				checkWord(TestWin, $sformatf("row %0d col %0d entry %0d", row, col, chkIdx[j]),
					chkWord[j], window[chkIdx[j]]);
				chkSeen[j] = 1'b1;
			end
		end
	endtask

	initial begin
		int seedDummy;
		int nStore;
		int k;
		int busyCycles;
		int run;
		int pos;
		int failedTests;
		seedDummy = $urandom(62613);
		rstn = 1'b0;
		start = 1'b0;
		bankData = '0;
		for (int t = 0; t < TestN; t++) testErrors[t] = 0;
		for (int b = 0; b < `BANKS; b++) begin
			for (int a = 0; a < Depth; a++) mem[b][a] = $urandom;
		end
		$readmemh("tb/parser_stimulus.txt", stim);
		nStore = int'(stim[0]);
		for (int i = 0; i < nStore; i++) begin
			mem[stim[1 + 3 * i]][stim[2 + 3 * i]] = stim[3 + 3 * i];
		end
		// bank output registers start on word 0
		for (int b = 0; b < `BANKS; b++) begin
			pending[b] = mem[b][0];
		end
		k = 1 + 3 * nStore;
		nChecks = int'(stim[k]);
		if (nChecks > 32) begin
			$display("stimulus file lists too many window checks");
			testErrors[TestWin]++;
			nChecks = 32;
		end
		for (int j = 0; j < nChecks; j++) begin
			chkRow[j] = int'(stim[k + 1 + 4 * j]);
			chkCol[j] = int'(stim[k + 2 + 4 * j]);
			chkIdx[j] = int'(stim[k + 3 + 4 * j]);
			chkWord[j] = stim[k + 4 + 4 * j];
			chkSeen[j] = 1'b0;
		end

		repeat (ResetCycles) @(negedge clk);
		rstn = 1'b1;
		@(negedge clk);
		checkBit(TestIdle, "busy", 1'b0, busy);
		checkBit(TestIdle, "macValid", 1'b0, macValid);
		checkMask(TestIdle, "chipSel", '0, chipSel);
		checkAddr(TestIdle, "bankAddr", '0, bankAddr);
		for (int i = 0; i < `BANKS; i++) begin
			checkWord(TestIdle, $sformatf("window entry %0d", i), '0, window[i]);
		end
		finishTest(TestIdle);

		////////////////////////////////////////////////////////////
		// one full frame
		////////////////////////////////////////////////////////////
		start = 1'b1;
		busyCycles = 0;
		run = 0;
		pos = 0;
		while (1) begin
			@(negedge clk);
			if (!busy) break;
			busyCycles++;
			if (macValid) begin
				run++;
				if (run == VldHigh) samplePosition(pos);   // window settled
			end else if (run != 0) begin
				checkCount(TestValid, $sformatf("high time at position %0d", pos), VldHigh, run);
				pos++;
				run = 0;
			end
		end
		start = 1'b0;   // before the FSM can leave IDLE again
		checkCount(TestFrame, "busy cycles", FrameLen, busyCycles);
		checkCount(TestValid, "positions", `COLS * `ROWS, pos);
		for (int j = 0; j < nChecks; j++) begin
			if (!chkSeen[j]) begin
				$display("window check %0d at row %0d col %0d was never sampled", j, chkRow[j],
					chkCol[j]);
				testErrors[TestWin]++;
			end
		end
		repeat (HoldCycles) begin
			@(negedge clk);
			checkBit(TestHold, "busy with start low", 1'b0, busy);
		end
		for (int t = TestFrame; t < TestN; t++) finishTest(t);

		failedTests = 0;
		for (int t = 0; t < TestN; t++) if (testErrors[t] != 0) failedTests++;
		$display("%0d tests, %0d passed, %0d failed", TestN, TestN - failedTests, failedTests);
		if (failedTests == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		#((ResetCycles + 3 * FrameLen + HoldCycles) * Period);
		$display("watchdog expired, frame did not finish in time");
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/parser_stimulus.txt */
// bank section: count, then lines of bank, address, word
// check section: count, then lines of row, column, window entry (row*4 + column), word
A
0 0 5A000000
3 2 5A030200
8 1 5A080100
5 3 5A050300
3 8 5A030800
F 1 5A0F0100
4 5 5A040500
9 0 5A090000
4 0 5A040000
D 6 5A0D0600
11
0 0 0 00000000
0 0 4 00000000
0 0 3 00000000
0 0 5 5A000000
0 3 6 5A030200
0 3 F 5A080100
1 7 3 00000000
1 7 0 5A050300
1 7 E 5A030800
2 2 0 5A0F0100
2 2 9 5A040500
3 4 A 5A0D0600
3 4 C 5A030200
5 0 C 00000000
5 0 D 00000000
5 0 6 5A090000
5 0 1 5A040000

/* src.f */
+incdir+design
design/parser_pkg.sv
design/scanFsm.sv
design/bankAddrGen.sv
design/windowAssembler.sv
design/featureParser.sv
tb/featureParser_asserts.sv
tb/featureParser_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module featureParser_tb -o featureParserSim

out=$(./obj_dir/featureParserSim)
echo "$out"

if grep -qx "Regression passed" <<< "$out"; then
	exit 0
fi
exit 1
